// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = fwrisc_sys_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
PASS_TEXT  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== fwrisc_reg_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwrisc_reg_arbiter(
	input  logic                    clock,
	input  logic                    reset,
	input  fwrisc_sys_pkg::wb_req_t exec_req,
	output fwrisc_sys_pkg::wb_rsp_t exec_rsp,
	input  fwrisc_sys_pkg::wb_req_t host_req,
	output fwrisc_sys_pkg::wb_rsp_t host_rsp,
	output fwrisc_sys_pkg::wb_req_t mem_req,
	input  fwrisc_sys_pkg::wb_rsp_t mem_rsp
);

	typedef enum logic [1:0] {
		OWN_IDLE,
		OWN_EXEC,
		OWN_HOST
	} owner_e;

	owner_e owner; // registered grant
	owner_e sel;   // grant in effect this cycle

	// priority decision only while nobody holds the bus
	always_comb begin
		sel = owner;
		if (owner == OWN_IDLE) begin
			if (exec_req.cyc) begin
				sel = OWN_EXEC; // sequencer wins a tie
			end else if (host_req.cyc) begin
				sel = OWN_HOST;
			end
		end
	end

	// grant held as long as the owner keeps cyc high
	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= OWN_IDLE;
		end else begin
			case (sel)
				OWN_EXEC: owner <= exec_req.cyc ? OWN_EXEC : OWN_IDLE;
				OWN_HOST: owner <= host_req.cyc ? OWN_HOST : OWN_IDLE;
				default:  owner <= OWN_IDLE;
			endcase
		end
	end

	always_comb begin
		mem_req  = '0;
		exec_rsp = '0;
		host_rsp = '0; // the waiting master sees no ack
		case (sel)
			OWN_EXEC: begin
				mem_req  = exec_req;
				exec_rsp = mem_rsp;
			end
			OWN_HOST: begin
				mem_req  = host_req;
				host_rsp = mem_rsp;
			end
			default: begin
				mem_req = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== fwrisc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwrisc_regfile(
	input  logic                    clock,
	input  logic                    reset,
	input  fwrisc_sys_pkg::wb_req_t wb_in,
	output fwrisc_sys_pkg::wb_rsp_t wb_out
);

	logic [31:0] regs [0:63]; // x0..x31, then the folded csrs
	logic [31:0] rd_dat_q;
	logic        ack_q;
	logic        strobe;

	// a new access, masked in the ack cycle so ack lasts one cycle
	assign strobe = wb_in.cyc && wb_in.stb && !ack_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= strobe;
		end
	end

	always_ff @(posedge clock) begin
		if (strobe) begin
			if (wb_in.we && wb_in.adr != 6'd0) begin
				regs[wb_in.adr] <= wb_in.dat; // x0 is hardwired
			end
			rd_dat_q <= (wb_in.adr == 6'd0) ? 32'd0 : regs[wb_in.adr];
		end
	end

	always_comb begin
		wb_out.ack = ack_q;
		wb_out.dat = rd_dat_q;
	end

endmodule

`default_nettype wire

// ==== fwrisc_sys_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwrisc_sys_exec(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     decode_valid,
	input  fwrisc_sys_pkg::sys_req_t sys_req,
	output logic                     exec_ready,
	output logic                     instr_complete,
	output logic [31:0]              next_pc,
	output fwrisc_sys_pkg::wb_req_t  bus_req,
	input  fwrisc_sys_pkg::wb_rsp_t  bus_rsp
);
	import fwrisc_sys_pkg::*;

	exec_state_e state;
	sys_op_e     op_q;     // op of the instruction in flight
	logic [31:0] epc_q;    // pc of the trapping instruction
	logic [31:0] target_q; // redirect target, already word aligned
	logic [31:0] cause;
	logic        access;
	logic        accept;

	assign exec_ready     = (state == IDLE);
	assign instr_complete = (state == DONE);
	assign next_pc        = target_q;
	assign accept         = decode_valid && exec_ready;

	// cyc and stb stay up across the whole trap sequence
	assign access = (state == WR_MEPC) || (state == WR_MCAUSE) ||
		(state == WR_MTVAL) || (state == RD_MTVEC);

	always_comb begin
		case (op_q)
			SYS_ECALL:  cause = MCAUSE_ECALL;
			SYS_EBREAK: cause = MCAUSE_EBREAK;
			default:    cause = 32'd0; // mret writes no cause
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						// mret only redirects, no csr traffic
						state <= (sys_req.op == SYS_MRET) ? DONE : WR_MEPC;
					end
				end
				WR_MEPC: begin
					if (bus_rsp.ack) state <= WR_MCAUSE;
				end
				WR_MCAUSE: begin
					if (bus_rsp.ack) state <= WR_MTVAL;
				end
				WR_MTVAL: begin
					if (bus_rsp.ack) state <= RD_MTVEC;
				end
				RD_MTVEC: begin
					if (bus_rsp.ack) state <= DONE;
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q     <= sys_req.op;
			epc_q    <= sys_req.pc;
			target_q <= sys_req.op_a & ~32'h3; // mret return, overwritten on traps
		end else if (state == RD_MTVEC && bus_rsp.ack) begin
			target_q <= bus_rsp.dat & ~32'h3; // trap vector, direct mode
		end
	end

	always_comb begin
		bus_req     = '0;
		bus_req.cyc = access;
		bus_req.stb = access;
		bus_req.we  = access && (state != RD_MTVEC);
		case (state)
			WR_MEPC: begin
				bus_req.adr = CSR_MEPC;
				bus_req.dat = epc_q;
			end
			WR_MCAUSE: begin
				bus_req.adr = CSR_MCAUSE;
				bus_req.dat = cause;
			end
			WR_MTVAL: begin
				bus_req.adr = CSR_MTVAL;
				bus_req.dat = 32'd0; // no faulting address for ecall/ebreak
			end
			RD_MTVEC: begin
				bus_req.adr = CSR_MTVEC;
			end
			default: begin
				bus_req.adr = 6'd0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== fwrisc_sys_pkg.sv ====
`default_nettype none

package fwrisc_sys_pkg;

	// system instructions the sequencer understands
	typedef enum logic [1:0] {
		SYS_ECALL,
		SYS_EBREAK,
		SYS_MRET
	} sys_op_e;

	// sequencer states, one bus access per WR_/RD_ state
	typedef enum logic [2:0] {
		IDLE,
		WR_MEPC,
		WR_MCAUSE,
		WR_MTVAL,
		RD_MTVEC,
		DONE
	} exec_state_e;

	// csr numbers folded into the upper half of the register file
	localparam logic [5:0] CSR_MTVEC  = 6'd37;
	localparam logic [5:0] CSR_MEPC   = 6'd41;
	localparam logic [5:0] CSR_MCAUSE = 6'd42;
	localparam logic [5:0] CSR_MTVAL  = 6'd43;

	localparam logic [31:0] MCAUSE_ECALL  = 32'd11; // environment call from M-mode
	localparam logic [31:0] MCAUSE_EBREAK = 32'd3;  // breakpoint

	typedef struct packed {
		sys_op_e     op;
		logic [31:0] pc;
		logic [31:0] op_a; // mret return target
	} sys_req_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [5:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== fwrisc_sys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwrisc_sys_tb;
	import fwrisc_sys_pkg::*;

	localparam int WAIT_LIMIT = 100; // cycles before any wait gives up
	localparam int MIX_OPS    = 40;

	typedef struct packed {
		logic [31:0] next_pc;
		logic [31:0] mepc;
		logic [31:0] mcause;
		logic [31:0] mtval;
	} trap_result_t;

	logic         clock;
	logic         reset;
	logic         decode_valid;
	sys_req_t     sys_req;
	logic         exec_ready;
	logic         instr_complete;
	logic [31:0]  next_pc;
	wb_req_t      host_req;
	wb_rsp_t      host_rsp;
	integer       seed;
	int           error_count;
	int           checks_done;
	logic [31:0]  exp_next_pc;   // due on the next instr_complete
	logic [31:0]  exp_rd_dat;    // due on the next host read ack
	logic [31:0]  shadow [0:63]; // last value the host wrote
	logic [31:0]  mtvec_val;
	trap_result_t csr_state;     // expected mepc, mcause, mtval

	tb_clock_gen clock_gen_inst (.clock(clock), .reset(reset));

	fwrisc_sys_top fwrisc_sys_top_inst (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.sys_req        (sys_req),
		.exec_ready     (exec_ready),
		.instr_complete (instr_complete),
		.next_pc        (next_pc),
		.host_req       (host_req),
		.host_rsp       (host_rsp)
	);

	task automatic abort_run;
		error_count++;
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	endtask

	task automatic explain_failure(input string what);
		$display("ERROR: %s", what);
		abort_run();
	endtask

	// expected trap entry or mret result, csrs not written keep their prev values
	function automatic trap_result_t expected_sys_result(input sys_op_e op,
		input logic [31:0] pc, input logic [31:0] op_a, input logic [31:0] mtvec,
		input trap_result_t prev);
		trap_result_t res;
		res = prev;
		if (op == SYS_MRET) begin
			res.next_pc = {op_a[31:2], 2'b00};
		end else begin
			res.next_pc = {mtvec[31:2], 2'b00};
			res.mepc    = pc;
			res.mcause  = (op == SYS_ECALL) ? 32'd11 : 32'd3;
			res.mtval   = 32'd0;
		end
		return res;
	endfunction

	function automatic logic [31:0] read_model(input logic [5:0] adr);
		return (adr == 6'd0) ? 32'd0 : shadow[adr];
	endfunction

	always @(negedge clock) begin
		if (!reset) begin
			if (instr_complete) begin
				assert (next_pc === exp_next_pc)
				else show_mismatch("next_pc", next_pc, exp_next_pc);
				checks_done++;
			end
			if (host_rsp.ack && host_req.cyc && !host_req.we) begin
				assert (host_rsp.dat === exp_rd_dat)
				else show_mismatch($sformatf("host_rsp.dat (adr %0d)", host_req.adr),
					host_rsp.dat, exp_rd_dat);
				checks_done++;
			end
		end
	end

	// one classic transfer with stb dropped the cycle after ack
	task automatic host_access(input logic we, input logic [5:0] adr, input logic [31:0] dat);
		int waited;
		@(posedge clock);
		host_req.cyc <= 1'b1;
		host_req.stb <= 1'b1;
		host_req.we  <= we;
		host_req.adr <= adr;
		host_req.dat <= dat;
		waited = 0;
		@(negedge clock);
		while (!host_rsp.ack) begin
			if (waited >= WAIT_LIMIT) explain_failure("host access never got an ack");
			waited++;
			@(negedge clock);
		end
		@(posedge clock);
		host_req <= '0;
	endtask

	task automatic host_write(input logic [5:0] adr, input logic [31:0] dat);
		if (adr != 6'd0) shadow[adr] = dat;
		if (adr == CSR_MTVEC) mtvec_val = dat;
		host_access(1'b1, adr, dat);
	endtask

	task automatic host_read_check(input logic [5:0] adr, input logic [31:0] exp);
		exp_rd_dat = exp;
		host_access(1'b0, adr, 32'd0);
	endtask

	task automatic check_csrs;
		host_read_check(CSR_MEPC, csr_state.mepc);
		host_read_check(CSR_MCAUSE, csr_state.mcause);
		host_read_check(CSR_MTVAL, csr_state.mtval);
		host_read_check(CSR_MTVEC, mtvec_val);
	endtask

	task automatic run_sys_op(input sys_op_e op, input logic [31:0] pc, input logic [31:0] op_a);
		trap_result_t res;
		int waited;
		res = expected_sys_result(op, pc, op_a, mtvec_val, csr_state);
		exp_next_pc = res.next_pc;
		@(posedge clock);
		decode_valid <= 1'b1;
		sys_req.op   <= op;
		sys_req.pc   <= pc;
		sys_req.op_a <= op_a;
		waited = 0;
		@(negedge clock);
		while (!exec_ready) begin
			if (waited >= WAIT_LIMIT) explain_failure("sequencer never became ready");
			waited++;
			@(negedge clock);
		end
		@(posedge clock); // request taken on this edge
		decode_valid <= 1'b0;
		waited = 1;
		@(negedge clock);
		while (!instr_complete) begin
			if (waited >= WAIT_LIMIT) explain_failure("instr_complete never arrived");
			waited++;
			@(negedge clock);
		end
		assert (!exec_ready) else explain_failure("exec_ready high during instr_complete");
		if (op == SYS_MRET) begin
			assert (waited == 1)
			else explain_failure("MRET did not complete one cycle after acceptance");
		end else begin
			assert (waited >= 9)
			else explain_failure("trap completed faster than four bus accesses");
		end
		csr_state = res;
		@(negedge clock);
		assert (!instr_complete)
		else explain_failure("instr_complete stayed high for a second cycle");
		assert (exec_ready)
		else explain_failure("exec_ready still low in the cycle after instr_complete");
	endtask

	task automatic check_reset_state;
		int waited;
		waited = 0;
		@(negedge clock);
		while (reset) begin
			if (waited >= WAIT_LIMIT) explain_failure("reset was never released");
			waited++;
			@(negedge clock);
		end
		assert (exec_ready === 1'b1) else show_mismatch("exec_ready", 32'(exec_ready), 32'd1);
		assert (instr_complete === 1'b0)
		else show_mismatch("instr_complete", 32'(instr_complete), 32'd0);
		assert (host_rsp.ack === 1'b0) else show_mismatch("host_rsp.ack", 32'(host_rsp.ack), 32'd0);
	endtask

	task automatic exercise_host_port;
		logic [5:0] adr_list [0:15];
		for (int i = 0; i < 16; i++) begin
			adr_list[i] = 6'($unsigned($random(seed)));
			host_write(adr_list[i], $random(seed));
		end
		for (int i = 0; i < 16; i++) host_read_check(adr_list[i], read_model(adr_list[i]));
		host_write(6'd0, 32'hdead_beef); // x0 stays zero
		host_read_check(6'd0, 32'd0);
	endtask

	task automatic run_trap_checks;
		host_write(CSR_MTVEC, $random(seed)); // random low bits must be masked off
		host_write(CSR_MTVAL, 32'hffff_ffff); // stale value the trap has to clear
		run_sys_op(SYS_ECALL, $random(seed), 32'd0);
		check_csrs();
		host_write(CSR_MTVAL, 32'hffff_ffff);
		run_sys_op(SYS_EBREAK, $random(seed), 32'd0);
		check_csrs();
		run_sys_op(SYS_MRET, $random(seed), $random(seed));
		check_csrs();
	endtask

	task automatic run_mixed_traffic;
		sys_op_e     op;
		logic [31:0] pc;
		logic [31:0] op_a;
		logic [5:0]  gpr;
		logic [31:0] value;
		int          lead;
		for (int n = 0; n < MIX_OPS; n++) begin
			if ($unsigned($random(seed)) % 4 == 0) host_write(CSR_MTVEC, $random(seed));
			case ($unsigned($random(seed)) % 3)
				0:       op = SYS_ECALL;
				1:       op = SYS_EBREAK;
				default: op = SYS_MRET;
			endcase
			pc    = $random(seed);
			op_a  = $random(seed);
			gpr   = 6'(1 + $unsigned($random(seed)) % 31);
			value = $random(seed);
			lead  = $unsigned($random(seed)) % 6;
			fork
				run_sys_op(op, pc, op_a);
				begin
					repeat (lead) @(posedge clock); // vary who reaches the arbiter first
					host_write(gpr, value);
					host_read_check(gpr, read_model(gpr));
					host_read_check(6'd0, 32'd0);
				end
			join
			check_csrs();
		end
	endtask

	initial begin
		seed         = 21;
		error_count  = 0;
		checks_done  = 0;
		decode_valid = 1'b0;
		sys_req      = '0;
		host_req     = '0;
		exp_next_pc  = '0;
		exp_rd_dat   = '0;
		mtvec_val    = '0;
		csr_state    = '0;
		check_reset_state();
		exercise_host_port();
		run_trap_checks();
		run_mixed_traffic();
		if (checks_done == 0) explain_failure("no DUT response was ever compared");
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== fwrisc_sys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwrisc_sys_top(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     decode_valid,
	input  fwrisc_sys_pkg::sys_req_t sys_req,
	output logic                     exec_ready,
	output logic                     instr_complete,
	output logic [31:0]              next_pc,
	input  fwrisc_sys_pkg::wb_req_t  host_req,
	output fwrisc_sys_pkg::wb_rsp_t  host_rsp
);
	import fwrisc_sys_pkg::*;

	wb_req_t exec_req; // sequencer side of the arbiter
	wb_rsp_t exec_rsp;
	wb_req_t mem_req;  // arbiter to register file
	wb_rsp_t mem_rsp;

	fwrisc_sys_exec fwrisc_sys_exec_inst (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.sys_req        (sys_req),
		.exec_ready     (exec_ready),
		.instr_complete (instr_complete),
		.next_pc        (next_pc),
		.bus_req        (exec_req),
		.bus_rsp        (exec_rsp)
	);

	// sequencer and host share the one register file
	fwrisc_reg_arbiter fwrisc_reg_arbiter_inst (
		.clock    (clock),
		.reset    (reset),
		.exec_req (exec_req),
		.exec_rsp (exec_rsp),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	fwrisc_regfile fwrisc_regfile_inst (
		.clock  (clock),
		.reset  (reset),
		.wb_in  (mem_req),
		.wb_out (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
fwrisc_sys_pkg.sv
fwrisc_regfile.sv
fwrisc_reg_arbiter.sv
fwrisc_sys_exec.sv
fwrisc_sys_top.sv
tb_clock_gen.sv
fwrisc_sys_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen(
	output logic clock,
	output logic reset
);

	logic [2:0] cycles = 3'd0; // rising edges seen so far
	logic       reset_q = 1'b1;

	assign reset = reset_q;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	// reset held over the first four rising edges
	always @(posedge clock) begin
		if (cycles != 3'd4) cycles <= cycles + 3'd1;
		reset_q <= (cycles < 3'd3);
	end

endmodule

`default_nettype wire
